// File: include/mem_ctrl_cfg.svh
// ####################
// widths, limits and FIFO depth
// for the memory access controller
// ####################
`ifndef MEM_CTRL_CFG_SVH
`define MEM_CTRL_CFG_SVH

// byte address, 128 KiB space
`define MC_ADDR_W     17
`define MC_WORD_W     32    // one cache access
`define MC_SCALAR_W   64    // scalar register

// vector register, up to 8 elements of at most 4 bytes
`define MC_MAX_ELEMS  8
`define MC_VREG_W     256
`define MC_LEN_W      4     // holds 0..8

// word operations buffered between splitter and cache port
`define MC_FIFO_DEPTH 4

`endif

// File: rtl/mc_req_pkg.sv
// ####################
// core side request types
// size code and legality check
// ####################
package mc_req_pkg;

    // byte and half only for vectors, dword only for scalars
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_half  = 2'd1,
        size_word  = 2'd2,
        size_dword = 2'd3
    } elem_size_e;

    function automatic logic size_legal(input logic vector, input elem_size_e size);
        logic ok;
        if (vector) begin
            ok = (size != size_dword);
        end else begin
            ok = (size == size_word) || (size == size_dword);
        end
        return ok;
    endfunction

endpackage

// File: rtl/mc_bus_pkg.sv
// ####################
// cache side word operation
// and its field types
// ####################
`include "mem_ctrl_cfg.svh"

package mc_bus_pkg;

    typedef logic [`MC_ADDR_W-1:0] addr_t;
    typedef logic [`MC_WORD_W-1:0] word_t;
    typedef logic [2:0]            lane_t;    // element index within the vector

    // one single cache access
    typedef struct packed {
        addr_t                  addr;
        mc_req_pkg::elem_size_e size;     // dword halves go out as word
        logic                   store;
        logic                   active;   // cleared for masked-off elements
        logic                   vector;
        lane_t                  lane;     // scalar: 0 low word, 1 high word
        logic                   first;
        logic                   last;
        word_t                  wdata;    // right-aligned
    } word_op_t;

endpackage

// File: rtl/access_splitter.sv
// ####################
// request latch and splitter
// one word operation per element or word
// ####################
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module access_splitter (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic                       req_store,
    input  logic                       req_vector,
    input  mc_req_pkg::elem_size_e     req_size,
    input  logic [`MC_ADDR_W-1:0]      req_addr,
    input  logic [`MC_LEN_W-1:0]       req_len,
    input  logic                       req_vm,
    input  logic [`MC_MAX_ELEMS-1:0]   req_mask,
    input  logic [`MC_SCALAR_W-1:0]    req_scalar_wdata,
    input  logic [`MC_VREG_W-1:0]      req_vector_wdata,
    input  logic                       full,
    output logic                       push,
    output mc_bus_pkg::word_op_t       op
);

    localparam int ADDR_W = `MC_ADDR_W;
    localparam int LEN_W  = `MC_LEN_W;

    logic                     busy;
    logic                     accept;
    logic [LEN_W-1:0]         idx;        // current element
    logic [LEN_W-1:0]         n_ops_q;
    logic                     store_q;
    logic                     vector_q;
    logic                     vm_q;
    mc_req_pkg::elem_size_e   size_q;
    logic [ADDR_W-1:0]        addr_q;
    logic [ADDR_W-1:0]        step;
    logic [`MC_MAX_ELEMS-1:0] mask_q;
    logic [`MC_SCALAR_W-1:0]  swdata_q;
    logic [`MC_VREG_W-1:0]    vwdata_q;
    logic [`MC_WORD_W-1:0]    elem_data;

    assign req_ready = !busy;
    assign accept    = req_valid && req_ready;
    assign push      = busy && !full;
    assign step      = vector_q ? (ADDR_W'(1) << size_q) : ADDR_W'(4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (push) begin
            idx <= idx + 1'b1;
            if (op.last) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            store_q  <= req_store;
            vector_q <= req_vector;
            vm_q     <= req_vm;
            size_q   <= req_size;
            addr_q   <= req_addr;
            mask_q   <= req_mask;
            swdata_q <= req_scalar_wdata;
            vwdata_q <= req_vector_wdata;
            if (req_vector) begin
                n_ops_q <= req_len;
            end else begin
                n_ops_q <= (req_size == mc_req_pkg::size_dword) ? LEN_W'(2) : LEN_W'(1);
            end
        end else if (push) begin
            addr_q <= addr_q + step;
        end
    end

    // element slice of the store data
    always_comb begin
        if (!vector_q) begin
            elem_data = idx[0] ? swdata_q[63:32] : swdata_q[31:0];
        end else begin
            case (size_q)
                mc_req_pkg::size_byte: elem_data = {24'b0, vwdata_q[{idx[2:0], 3'b000} +: 8]};
                mc_req_pkg::size_half: elem_data = {16'b0, vwdata_q[{idx[2:0], 4'b0000} +: 16]};
                default:               elem_data = vwdata_q[{idx[2:0], 5'b00000} +: 32];
            endcase
        end
    end

    always_comb begin
        op.addr   = addr_q;
        op.size   = vector_q ? size_q : mc_req_pkg::size_word;
        op.store  = store_q;
        op.active = !vector_q || vm_q || mask_q[idx[2:0]];
        op.vector = vector_q;
        op.lane   = idx[2:0];
        op.first  = (idx == '0);
        op.last   = (idx == n_ops_q - 1'b1);
        op.wdata  = elem_data;
    end

    a_size_legal: assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> mc_req_pkg::size_legal(req_vector, req_size)
            && (!req_vector || (req_len != '0 && req_len <= LEN_W'(`MC_MAX_ELEMS))));

    // core keeps the request up until it is taken
    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid);

endmodule

// File: rtl/op_fifo.sv
// ####################
// circular buffer FIFO
// payload type is a parameter
// ####################
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module op_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `MC_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t din,
    output logic     full,
    input  logic     pop,
    output logic     not_empty,
    output payload_t head
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) pop |-> not_empty);

endmodule

// File: rtl/cache_port.sv
// ####################
// cache request/response port
// load result assembly and done pulse
// ####################
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module cache_port (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     not_empty,
    input  mc_bus_pkg::word_op_t     head,
    output logic                     pop,
    output logic                     cache_req_valid,
    input  logic                     cache_req_ready,
    output logic                     cache_req_store,
    output mc_bus_pkg::addr_t        cache_req_addr,
    output mc_req_pkg::elem_size_e   cache_req_size,
    output mc_bus_pkg::word_t        cache_req_wdata,
    input  logic                     cache_rsp_valid,
    input  mc_bus_pkg::word_t        cache_rsp_rdata,
    output logic                     done,
    output logic [`MC_SCALAR_W-1:0]  scalar_rdata,
    output logic [`MC_VREG_W-1:0]    vector_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } state_e;

    state_e                  state;
    logic [`MC_VREG_W-1:0]   vec_next;
    logic [`MC_SCALAR_W-1:0] sc_next;

    // head only moves on pop, so the fields hold while waiting
    assign cache_req_valid = (state == st_req);
    assign cache_req_store = head.store;
    assign cache_req_addr  = head.addr;
    assign cache_req_size  = head.size;
    assign cache_req_wdata = head.wdata;

    assign pop = (state == st_idle && not_empty && !head.active)   // masked off, skip
              || (state == st_wait && cache_rsp_valid);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            done <= pop && head.last;
            case (state)
                st_idle: if (not_empty && head.active) state <= st_req;
                st_req:  if (cache_req_ready) state <= st_wait;
                st_wait: if (cache_rsp_valid) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // first op of a load starts from zero, so skipped and unused lanes stay zero
    always_comb begin
        vec_next = head.first ? '0 : vector_rdata;
        sc_next  = head.first ? '0 : scalar_rdata;
        if (head.active) begin
            if (head.vector) begin
                case (head.size)
                    mc_req_pkg::size_byte: vec_next[{head.lane, 3'b000} +: 8] = cache_rsp_rdata[7:0];
                    mc_req_pkg::size_half:
                        vec_next[{head.lane, 4'b0000} +: 16] = cache_rsp_rdata[15:0];
                    default: vec_next[{head.lane, 5'b00000} +: 32] = cache_rsp_rdata;
                endcase
            end else if (head.lane[0]) begin
                sc_next[63:32] = cache_rsp_rdata;   // dword high half
            end else if (head.last) begin
                sc_next = {{(`MC_SCALAR_W - `MC_WORD_W){cache_rsp_rdata[`MC_WORD_W-1]}},
                           cache_rsp_rdata};
            end else begin
                sc_next[31:0] = cache_rsp_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop && !head.store) begin
            vector_rdata <= vec_next;
            scalar_rdata <= sc_next;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        cache_req_valid && !cache_req_ready |=> cache_req_valid
            && $stable(cache_req_addr) && $stable(cache_req_wdata)
            && $stable(cache_req_store) && $stable(cache_req_size));

    // one outstanding access, responses only while waiting
    a_rsp_expected: assert property (@(posedge clk) disable iff (!arst_n)
        cache_rsp_valid |-> state == st_wait);

endmodule

// File: rtl/mem_ctrl_top.sv
// ####################
// memory access controller top
// splitter, op FIFO and cache port
// ####################
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module mem_ctrl_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic                     req_store,
    input  logic                     req_vector,
    input  mc_req_pkg::elem_size_e   req_size,
    input  logic [`MC_ADDR_W-1:0]    req_addr,
    input  logic [`MC_LEN_W-1:0]     req_len,
    input  logic                     req_vm,
    input  logic [`MC_MAX_ELEMS-1:0] req_mask,
    input  logic [`MC_SCALAR_W-1:0]  req_scalar_wdata,
    input  logic [`MC_VREG_W-1:0]    req_vector_wdata,
    output logic                     done,
    output logic [`MC_SCALAR_W-1:0]  scalar_rdata,
    output logic [`MC_VREG_W-1:0]    vector_rdata,
    output logic                     cache_req_valid,
    input  logic                     cache_req_ready,
    output logic                     cache_req_store,
    output mc_bus_pkg::addr_t        cache_req_addr,
    output mc_req_pkg::elem_size_e   cache_req_size,
    output mc_bus_pkg::word_t        cache_req_wdata,
    input  logic                     cache_rsp_valid,
    input  mc_bus_pkg::word_t        cache_rsp_rdata
);

    logic                 push;
    logic                 full;
    logic                 pop;
    logic                 not_empty;
    mc_bus_pkg::word_op_t split_op;
    mc_bus_pkg::word_op_t head_op;

    access_splitter u_splitter (
        .clk, .arst_n, .req_valid, .req_ready, .req_store, .req_vector, .req_size,
        .req_addr, .req_len, .req_vm, .req_mask, .req_scalar_wdata, .req_vector_wdata,
        .full, .push, .op(split_op)
    );

    op_fifo #(.payload_t(mc_bus_pkg::word_op_t), .DEPTH(`MC_FIFO_DEPTH)) u_fifo (
        .clk, .arst_n, .push, .din(split_op), .full, .pop, .not_empty, .head(head_op)
    );

    cache_port u_port (
        .clk, .arst_n, .not_empty, .head(head_op), .pop,
        .cache_req_valid, .cache_req_ready, .cache_req_store, .cache_req_addr,
        .cache_req_size, .cache_req_wdata, .cache_rsp_valid, .cache_rsp_rdata,
        .done, .scalar_rdata, .vector_rdata
    );

endmodule

// File: sim/data_cache_model.sv
// ####################
// data cache model
// byte memory with random stalls and response latency
// ####################
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module data_cache_model (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  logic                   req_store,
    input  mc_bus_pkg::addr_t      req_addr,
    input  mc_req_pkg::elem_size_e req_size,
    input  mc_bus_pkg::word_t      req_wdata,
    output logic                   rsp_valid,
    output mc_bus_pkg::word_t      rsp_rdata
);

    logic [7:0]        mem [2**`MC_ADDR_W];
    logic [31:0]       lfsr    = 32'hef15_8d4c;
    logic              ready_q = 1'b0;
    logic              rsp_q   = 1'b0;
    logic              pending = 1'b0;   // one access accepted, response not yet given
    logic [1:0]        delay   = 2'd0;
    mc_bus_pkg::word_t rdata_q = '0;

    assign req_ready = ready_q;
    assign rsp_valid = rsp_q;
    assign rsp_rdata = rdata_q;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16) ^ 8'h3c;
    endfunction

    // port outputs only move on posedge, so the coming handshake is known here
    always @(negedge clk or negedge arst_n) begin
        int   nbytes;
        logic stall_a;
        logic stall_b;
        if (!arst_n) begin
            for (int a = 0; a < 2**`MC_ADDR_W; a++) begin
                mem[a] = fill_byte(a);
            end
            ready_q = 1'b0;
            rsp_q   = 1'b0;
            pending = 1'b0;
        end else begin
            if (rsp_q) begin
                rsp_q   = 1'b0;   // taken on the last posedge
                pending = 1'b0;
            end else if (pending) begin
                if (delay == 2'd0) begin
                    rsp_q = 1'b1;
                end else begin
                    delay = delay - 2'd1;
                end
            end
            stall_a = next_bit();
            stall_b = next_bit();
            ready_q = !(stall_a && stall_b);   // low about one cycle in four
            if (req_valid && ready_q && !pending) begin
                nbytes  = 1 << req_size;
                rdata_q = '0;
                for (int b = 0; b < nbytes; b++) begin
                    if (req_store) begin
                        mem[mc_bus_pkg::addr_t'(req_addr + b)] = req_wdata[8*b +: 8];
                    end else begin
                        rdata_q[8*b +: 8] = mem[mc_bus_pkg::addr_t'(req_addr + b)];
                    end
                end
                pending = 1'b1;
                delay   = {next_bit(), next_bit()};   // 0..3 extra cycles
            end
        end
    end

endmodule

// File: sim/tb_mem_ctrl.sv
// ####################
// memory access controller testbench
// request table, shadow memory and done counting
// ####################
`timescale 1ns/1ps
`include "mem_ctrl_cfg.svh"

module tb_mem_ctrl;

    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic                   store;
        logic                   vector;
        mc_req_pkg::elem_size_e size;
        logic [`MC_ADDR_W-1:0]  addr;
        logic [`MC_LEN_W-1:0]   len;
        logic                   vm;
        logic [7:0]             mask;
        logic [`MC_VREG_W-1:0]  wdata;
    } row_t;

    typedef struct packed {
        logic                  load;
        logic                  vector;
        logic [`MC_VREG_W-1:0] data;
    } expect_t;

    logic                     clk = 1'b0;
    logic                     arst_n;
    logic                     req_valid, req_ready, req_store, req_vector, req_vm;
    mc_req_pkg::elem_size_e   req_size;
    logic [`MC_ADDR_W-1:0]    req_addr;
    logic [`MC_LEN_W-1:0]     req_len;
    logic [`MC_MAX_ELEMS-1:0] req_mask;
    logic [`MC_SCALAR_W-1:0]  req_scalar_wdata, scalar_rdata;
    logic [`MC_VREG_W-1:0]    req_vector_wdata, vector_rdata;
    logic                     done, cache_req_valid, cache_req_ready, cache_req_store;
    logic                     cache_rsp_valid;
    mc_bus_pkg::addr_t        cache_req_addr;
    mc_req_pkg::elem_size_e   cache_req_size;
    mc_bus_pkg::word_t        cache_req_wdata, cache_rsp_rdata;

    logic [7:0] shadow [2**`MC_ADDR_W];
    row_t       rows [$];
    expect_t    exp_q [$];   // one entry per accepted request
    expect_t    cur;
    int         done_count = 0;
    int         timer;

    always #2 clk = ~clk;

    mem_ctrl_top DUT (.*);

    data_cache_model cache (
        .clk, .arst_n, .req_valid(cache_req_valid), .req_ready(cache_req_ready),
        .req_store(cache_req_store), .req_addr(cache_req_addr), .req_size(cache_req_size),
        .req_wdata(cache_req_wdata), .rsp_valid(cache_rsp_valid), .rsp_rdata(cache_rsp_rdata)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                               input string what);
        if (got !== exp) begin
            stop_run($sformatf("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic add_row(input logic store, input logic vector,
                           input mc_req_pkg::elem_size_e size, input int addr, input int len,
                           input logic vm, input logic [7:0] mask, input logic [255:0] wdata);
        rows.push_back(row_t'{store, vector, size, `MC_ADDR_W'(addr), `MC_LEN_W'(len),
                              vm, mask, wdata});
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!req_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("timeout: req_ready stayed low");
            end
        end
    endtask

    // applies a request to the shadow memory, returns what a load must give back
    function automatic expect_t apply_row(input row_t r);
        expect_t               e;
        int                    esz;
        int                    n;
        logic [`MC_ADDR_W-1:0] a;
        e.load   = !r.store;
        e.vector = r.vector;
        e.data   = '0;
        esz = r.vector ? (1 << r.size) : 4;
        n   = r.vector ? int'(r.len) : ((r.size == mc_req_pkg::size_dword) ? 2 : 1);
        for (int i = 0; i < n; i++) begin
            if (!r.vector || r.vm || r.mask[i]) begin
                for (int b = 0; b < esz; b++) begin
                    a = r.addr + `MC_ADDR_W'(i * esz + b);
                    if (r.store) begin
                        shadow[a] = r.wdata[8 * (i * esz + b) +: 8];
                    end else begin
                        e.data[8 * (i * esz + b) +: 8] = shadow[a];
                    end
                end
            end
        end
        if (e.load && !r.vector && r.size == mc_req_pkg::size_word) begin
            e.data[63:32] = {32{e.data[31]}};   // sign extension
        end
        return e;
    endfunction

    // done pulses are matched to requests in order
    always @(negedge clk) begin
        if (arst_n && done) begin
            if (exp_q.size() == 0) begin
                stop_run("done pulse with no request in flight");
            end else begin
                cur = exp_q.pop_front();
                done_count++;
                if (cur.load && cur.vector) begin
                    check_value(vector_rdata, cur.data, "vector load data");
                end else if (cur.load) begin
                    check_value(`MC_VREG_W'(scalar_rdata), cur.data, "scalar load data");
                end
            end
        end
    end

    initial begin
        arst_n           = 1'b0;
        req_valid        = 1'b0;
        req_store        = 1'b0;
        req_vector       = 1'b0;
        req_size         = mc_req_pkg::size_word;
        req_addr         = '0;
        req_len          = '0;
        req_vm           = 1'b0;
        req_mask         = '0;
        req_scalar_wdata = '0;
        req_vector_wdata = '0;

        add_row(1'b1, 1'b0, mc_req_pkg::size_word, 'h100, 1, 1'b0, 8'h00, 256'h8765_4321);
        add_row(1'b0, 1'b0, mc_req_pkg::size_word, 'h100, 1, 1'b0, 8'h00, '0);
        add_row(1'b1, 1'b0, mc_req_pkg::size_dword, 'h200, 1, 1'b0, 8'h00,
                256'hfedc_ba98_0123_4567);
        add_row(1'b0, 1'b0, mc_req_pkg::size_dword, 'h200, 1, 1'b0, 8'h00, '0);
        add_row(1'b0, 1'b0, mc_req_pkg::size_word, 'h204, 1, 1'b0, 8'h00, '0);
        add_row(1'b1, 1'b1, mc_req_pkg::size_byte, 'h300, 8, 1'b0, 8'ha5,
                256'hf1e2_d3c4_b5a6_9788);
        add_row(1'b0, 1'b1, mc_req_pkg::size_byte, 'h300, 8, 1'b1, 8'h00, '0);
        add_row(1'b1, 1'b1, mc_req_pkg::size_half, 'h402, 5, 1'b0, 8'h16,
                256'h1111_2222_3333_4444_5555_6666_7777_8888);
        add_row(1'b0, 1'b1, mc_req_pkg::size_half, 'h400, 8, 1'b1, 8'h00, '0);
        add_row(1'b1, 1'b1, mc_req_pkg::size_word, 'h500, 8, 1'b0, 8'hcb,
                256'hdead_beef_0bad_f00d_cafe_babe_1357_9bdf_2468_ace0_8642_fdb9_7531_eca8_0f1e_2d3c);
        add_row(1'b0, 1'b1, mc_req_pkg::size_word, 'h500, 8, 1'b1, 8'h00, '0);
        add_row(1'b0, 1'b1, mc_req_pkg::size_word, 'h500, 6, 1'b0, 8'hb6, '0);
        add_row(1'b0, 1'b1, mc_req_pkg::size_byte, 'h2fe, 3, 1'b0, 8'hfa, '0);
        add_row(1'b0, 1'b1, mc_req_pkg::size_half, 'h1000, 8, 1'b1, 8'h00, '0);
        add_row(1'b0, 1'b0, mc_req_pkg::size_dword, 'h300, 1, 1'b0, 8'h00, '0);

        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        for (int a = 0; a < 2**`MC_ADDR_W; a++) begin
            shadow[a] = cache.mem[a];   // start from the cache fill pattern
        end

        foreach (rows[i]) begin
            wait_ready();
            exp_q.push_back(apply_row(rows[i]));
            req_valid        = 1'b1;
            req_store        = rows[i].store;
            req_vector       = rows[i].vector;
            req_size         = rows[i].size;
            req_addr         = rows[i].addr;
            req_len          = rows[i].len;
            req_vm           = rows[i].vm;
            req_mask         = rows[i].mask;
            req_scalar_wdata = rows[i].wdata[63:0];
            req_vector_wdata = rows[i].wdata;
            @(negedge clk);   // taken on the posedge in between
            req_valid = 1'b0;
        end

        timer = 0;
        while (done_count < rows.size()) begin
            @(negedge clk);
            timer++;
            if (timer > TIMEOUT * rows.size()) begin
                stop_run("timeout: not every request reported done");
            end
        end
        repeat (20) @(negedge clk);   // quiet window, catches extra done pulses
        $display("All checks passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
rtl/mc_req_pkg.sv
rtl/mc_bus_pkg.sv
rtl/access_splitter.sv
rtl/op_fifo.sv
rtl/cache_port.sv
rtl/mem_ctrl_top.sv
sim/data_cache_model.sv
sim/tb_mem_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of tb_mem_ctrl, verdict taken from the run log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_ctrl \
    -f verilog.f -o tb_mem_ctrl > build.log 2>&1 \
    && ./obj_dir/tb_mem_ctrl > sim.log 2>&1
grep -qx "All checks passed" sim.log && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }
